// ==== lcd_video_cfg_pkg.sv ====
// LCD video timing configuration
// Line geometry, pixel counter limits and the STAT mode encoding
`default_nettype none

package lcd_video_cfg_pkg;

    // ------------------------------
    // STAT mode field
    // ------------------------------
    typedef enum logic [1:0] {
        MODE_HBLANK = 2'b00,
        MODE_VBLANK = 2'b01,
        MODE_OAM    = 2'b10,
        MODE_XFER   = 2'b11
    } lcd_mode_t;

    // ------------------------------
    // Line and frame geometry
    // ------------------------------
    // Last dot group of a line, 4 ce per group
    localparam int H_LAST = 113;
    // Last line of a frame
    localparam int V_LAST = 153;
    // First vblank line
    localparam int V_VISIBLE = 144;
    // OAM scan length in dot groups at the start of a visible line
    localparam int OAM_GROUPS = 20;

    // ------------------------------
    // Pixel pipeline
    // ------------------------------
    // Pixels 0-7 are offscreen, 8-167 go to the panel
    localparam int PCNT_FIRST_VIS = 8;
    localparam int PCNT_LAST = 168;
    // Background tile fetch length in ce cycles
    localparam int FETCH_CYCLES = 6;

endpackage

`default_nettype wire

// ==== lcd_video_bus_pkg.sv ====
// LCD video bus types
// CPU register bus, line status between timer and pixel path, palette index
`default_nettype none

package lcd_video_bus_pkg;

    // ------------------------------
    // CPU register write bus
    // ------------------------------
    // 18 bits: select, write, address, data
    typedef struct packed {
        logic       sel_reg;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] di;
    } cpu_bus_t;

    // ------------------------------
    // Line status to pixel path
    // ------------------------------
    typedef struct packed {
        // Four-cycle pulse at the end of each line
        logic end_of_line;
        // Latched vblank flag of the current line
        logic vblank;
        // Start of a visible line, restarts the pixel counter
        logic pcnt_reset;
    } line_status_t;

    // ------------------------------
    // Palette index byte (0x68)
    // ------------------------------
    typedef struct packed {
        logic       auto_inc;
        logic       spare;
        logic [5:0] index;
    } pal_index_t;

    // Same byte seen raw on the bus or as its fields
    typedef union packed {
        logic [7:0] raw;
        pal_index_t f;
    } pal_index_u;

endpackage

`default_nettype wire

// ==== lcd_sync_ctrl.sv ====
// LCD re-enable synchroniser
// Holds the timing core in restart after LCDC is switched on until the
// real panel timing is caught, and drives the sync override outputs
`default_nettype none
`timescale 1ns/1ps

module lcd_sync_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ce,
    input  logic                         lcdc_on,
    input  logic                         lcd_vsync,
    input  lcd_video_cfg_pkg::lcd_mode_t mode_real,
    output logic                         restart,
    output logic                         overwrite,
    output logic                         vsync_overwrite,
    output logic                         lcd_on
);
    import lcd_video_cfg_pkg::*;

    typedef enum logic [2:0] {
        SYNC_OFF           = 3'd0,
        SYNC_WAIT_VSYNC    = 3'd1,
        SYNC_WAIT_VBL_REAL = 3'd2,
        SYNC_WAIT_OAM_REAL = 3'd3,
        SYNC_WAIT_CE       = 3'd4,
        SYNC_WAIT_HBL_REAL = 3'd5
    } sync_state_t;

    sync_state_t state;
    logic        lcdc_on_d;
    // Free running, masks lcd_on on all but one ce of 16
    logic [3:0]  ce_cnt;
    logic        in_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SYNC_OFF;
            restart   <= 1'b0;
            lcdc_on_d <= 1'b0;
            ce_cnt    <= 4'd0;
        end else begin
            if (ce) begin
                lcdc_on_d <= lcdc_on;
                ce_cnt    <= ce_cnt + 4'd1;
            end
            case (state)
                // LCDC bit 7 rising edge
                SYNC_OFF:
                    if (ce && lcdc_on && !lcdc_on_d)
                        state <= SYNC_WAIT_VSYNC;
                // Own frame start, hold the datapaths from here on
                SYNC_WAIT_VSYNC:
                    if (lcd_vsync) begin
                        state   <= SYNC_WAIT_VBL_REAL;
                        restart <= 1'b1;
                    end
                SYNC_WAIT_VBL_REAL:
                    if (mode_real == MODE_VBLANK)
                        state <= SYNC_WAIT_OAM_REAL;
                SYNC_WAIT_OAM_REAL:
                    if (ce && mode_real == MODE_OAM)
                        state <= SYNC_WAIT_CE;
                // Release restart one ce after real OAM
                SYNC_WAIT_CE:
                    if (ce) begin
                        state   <= SYNC_WAIT_HBL_REAL;
                        restart <= 1'b0;
                    end
                SYNC_WAIT_HBL_REAL:
                    if (mode_real == MODE_HBLANK)
                        state <= SYNC_OFF;
                default:
                    state <= SYNC_OFF;
            endcase
        end
    end

    assign in_sync = (state == SYNC_WAIT_VBL_REAL) || (state == SYNC_WAIT_OAM_REAL);

    assign overwrite       = (state == SYNC_WAIT_VSYNC) || in_sync;
    assign vsync_overwrite = in_sync;
    assign lcd_on          = !(in_sync && ce_cnt != 4'd0);

    // Encoding stays inside the six defined states
    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {SYNC_OFF, SYNC_WAIT_VSYNC, SYNC_WAIT_VBL_REAL,
                      SYNC_WAIT_OAM_REAL, SYNC_WAIT_CE, SYNC_WAIT_HBL_REAL});

endmodule

`default_nettype wire

// ==== ppu_regs.sv ====
// LCD CPU register subset
// LCDC, STAT and SCX decode plus the 64-byte background colour palette
// with auto-incrementing index and mode 3 write blocking
`default_nettype none
`timescale 1ns/1ps

module ppu_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ce_cpu,
    input  logic                        is_gbc,
    input  logic                        is_gbc_mode,
    input  logic                        mode3,
    input  lcd_video_bus_pkg::cpu_bus_t cpu,
    output logic                        lcdc_on,
    output logic [2:0]                  scx_fine,
    output logic [7:0]                  pal_lo,
    output logic [7:0]                  pal_hi
);
    import lcd_video_bus_pkg::*;

    pal_index_u pal_index;
    // 64 bytes of background palette data
    logic [7:0] pal_ram [64];
    logic       reg_wr;
    logic       palette_gbc_ok;
    logic       data_wr;
    logic       pal_store;

    assign reg_wr = ce_cpu && cpu.sel_reg && cpu.wr;

    // Palette data is open on DMG hardware, on GBC only in colour mode
    assign palette_gbc_ok = !is_gbc || is_gbc_mode;

    assign data_wr   = reg_wr && cpu.addr == 8'h69 && palette_gbc_ok;
    // Palette RAM is busy while the line is drawn
    assign pal_store = data_wr && !mode3;

    // ------------------------------
    // Register decode
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            lcdc_on       <= 1'b0;
            scx_fine      <= 3'd0;
            pal_index.raw <= 8'h00;
        end else if (reg_wr) begin
            case (cpu.addr)
                // Only the display enable bit matters here
                8'h40: lcdc_on <= cpu.di[7];
                // STAT enables feed interrupts only, none in this core
                8'h41: ;
                // Fine scroll, coarse bits select tiles
                8'h43: scx_fine <= cpu.di[2:0];
                8'h68: pal_index.raw <= cpu.di;
                // Increment even when the store itself is blocked
                8'h69:
                    if (data_wr && pal_index.f.auto_inc)
                        pal_index.f.index <= pal_index.f.index + 6'd1;
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Palette RAM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (pal_store)
            pal_ram[pal_index.f.index] <= cpu.di;
    end

    // Colour 0 of palette 0, used as the fixed output colour
    assign pal_lo = pal_ram[0];
    assign pal_hi = pal_ram[1];

    // A write during mode 3 leaves the addressed byte as it was
    a_no_store_mode3: assert property (@(posedge clk) disable iff (reset)
        (data_wr && mode3) |=>
            pal_ram[$past(pal_index.f.index)] === $past(pal_ram[pal_index.f.index]));

endmodule

`default_nettype wire

// ==== line_timer.sv ====
// LCD line timer
// Dot divider, horizontal and vertical counters, vsync and STAT mode
`default_nettype none
`timescale 1ns/1ps

module line_timer #(
    parameter int H_LAST    = lcd_video_cfg_pkg::H_LAST,
    parameter int V_LAST    = lcd_video_cfg_pkg::V_LAST,
    parameter int V_VISIBLE = lcd_video_cfg_pkg::V_VISIBLE
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ce,
    input  logic                            restart,
    input  logic                            lcd_on,
    input  logic                            is_gbc,
    input  logic                            mode3_end,
    output lcd_video_bus_pkg::line_status_t status,
    output logic                            lcd_vsync,
    output lcd_video_cfg_pkg::lcd_mode_t    mode,
    output logic                            mode3
);
    import lcd_video_cfg_pkg::*;

    localparam int HW = $clog2(H_LAST + 1);
    localparam int VW = $clog2(V_LAST + 1);

    logic [1:0]    h_div;
    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          h_clk_en;
    logic          h_clk_en_neg;
    logic          hcnt_end;
    logic          vblank;
    logic          line_last;
    logic          v_tick;
    logic          end_of_line;
    logic          vblank_t;
    logic          vblank_l;
    logic          vcnt_eol_l;
    logic          vcnt_reset;
    logic          oam_window;
    logic          oam_l;
    logic          mode3_l;
    logic          mode_vblank;

    assign h_clk_en     = lcd_on && h_div == 2'd0;
    assign h_clk_en_neg = lcd_on && h_div == 2'd2;
    assign hcnt_end     = h_cnt == HW'(H_LAST);
    assign vblank       = v_cnt >= VW'(V_VISIBLE);
    assign line_last    = v_cnt == VW'(V_LAST);
    // GBC resets line 153 half a dot group later
    assign v_tick       = is_gbc ? h_clk_en_neg : h_clk_en;

    // ------------------------------
    // Dot divider and h counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            h_div <= 2'd0;
            h_cnt <= '0;
        end else if (ce) begin
            h_div <= h_div + 2'd1;
            if (h_clk_en)
                h_cnt <= hcnt_end ? '0 : h_cnt + 1'b1;
        end
    end

    // ------------------------------
    // End of line and vblank latch
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            end_of_line <= 1'b0;
            vblank_t    <= 1'b0;
            vblank_l    <= 1'b0;
        end else if (ce) begin
            vblank_l <= vblank_t;
            if (h_clk_en_neg && hcnt_end) begin
                end_of_line <= 1'b1;
            end else if (end_of_line) begin
                // Vblank is taken a few cycles into the new line
                if (h_clk_en)
                    vblank_t <= vblank;
                // Four ce long
                if (h_clk_en_neg)
                    end_of_line <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Line counter and vsync
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            v_cnt      <= '0;
            vcnt_eol_l <= 1'b0;
            vcnt_reset <= 1'b0;
            lcd_vsync  <= 1'b0;
        end else if (ce) begin
            if (!vcnt_reset && h_clk_en_neg && hcnt_end)
                v_cnt <= v_cnt + 1'b1;
            if (v_tick) begin
                vcnt_eol_l <= end_of_line;
                // Falling edge of end_of_line
                if (vcnt_eol_l && !end_of_line) begin
                    // Line 153 reads as 0 and holds there into the next line
                    vcnt_reset <= line_last;
                    if (line_last)
                        v_cnt <= '0;
                    // One line long, on the true line 0
                    lcd_vsync <= v_cnt == '0;
                end
            end
        end
    end

    // ------------------------------
    // Mode generation
    // ------------------------------
    // OAM scan opens each visible line
    assign oam_window = lcd_on && !vblank_t && h_cnt < HW'(OAM_GROUPS);
    assign mode3      = lcd_on && !mode3_end && !oam_window;

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            mode3_l <= 1'b0;
            oam_l   <= 1'b0;
        end else if (ce) begin
            mode3_l <= mode3;
            oam_l   <= oam_window;
        end
    end

    // DMG shows mode 0 for one cycle between vblank and OAM
    assign mode_vblank = is_gbc ? vblank_l : (vblank_l && vblank_t);

    assign mode = mode_vblank            ? MODE_VBLANK :
                  oam_l                  ? MODE_OAM    :
                  (mode3_l && !mode3_end) ? MODE_XFER   :
                                           MODE_HBLANK;

    assign status = '{end_of_line: end_of_line,
                      vblank:      vblank_t,
                      pcnt_reset:  h_clk_en && end_of_line && !vblank};

    a_vcnt_range: assert property (@(posedge clk) disable iff (reset)
        v_cnt <= VW'(V_LAST));

endmodule

`default_nettype wire

// ==== pixel_fetch.sv ====
// Background pixel pacing
// Fetch and shift timing, fine-scroll skip and the pixel strobe to the LCD
`default_nettype none
`timescale 1ns/1ps

module pixel_fetch (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ce,
    input  logic                            restart,
    input  logic                            mode3,
    input  lcd_video_bus_pkg::line_status_t status,
    input  logic [2:0]                      scx_fine,
    output logic                            mode3_end,
    output logic                            lcd_clkena
);
    import lcd_video_cfg_pkg::*;

    logic [2:0] fetch_cyc;
    logic [3:0] shift_cnt;
    logic [2:0] skip_cnt;
    logic       skip_done;
    logic [7:0] pcnt;
    logic       fetch_done;
    logic       shift_empty;
    logic       reload;
    logic       advance;
    logic       skip_end;
    logic       skip_en;
    logic       pcnt_end;
    logic       pix_strobe;
    logic       mode3_end_nxt;

    assign fetch_done  = fetch_cyc >= 3'(FETCH_CYCLES - 1);
    assign shift_empty = shift_cnt == 4'd0;
    // New tile goes in as the last pixel leaves
    assign reload      = fetch_done && shift_cnt <= 4'd1;
    // A pixel moves on every ce with data in the shifter
    assign advance     = mode3 && !shift_empty;

    assign skip_end = skip_cnt == scx_fine || &skip_cnt;
    assign skip_en  = !skip_done && !skip_end;
    assign pcnt_end = pcnt == 8'(PCNT_LAST);

    assign pix_strobe    = advance && !skip_en && pcnt >= 8'(PCNT_FIRST_VIS);
    assign mode3_end_nxt = (pix_strobe && pcnt == 8'(PCNT_LAST - 1)) || pcnt_end;

    // ------------------------------
    // Fetch and shift pacing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            fetch_cyc <= 3'd0;
            shift_cnt <= 4'd0;
        end else if (ce) begin
            if (!mode3) begin
                fetch_cyc <= 3'd0;
                shift_cnt <= 4'd0;
            end else begin
                if (!fetch_done)
                    fetch_cyc <= fetch_cyc + 3'd1;
                if (!shift_empty)
                    shift_cnt <= shift_cnt - 4'd1;
                if (reload) begin
                    shift_cnt <= 4'd8;
                    fetch_cyc <= 3'd0;
                end
            end
        end
    end

    // ------------------------------
    // Skip and pixel counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            skip_cnt  <= 3'd0;
            skip_done <= 1'b0;
            pcnt      <= 8'd0;
            mode3_end <= 1'b0;
        end else if (ce) begin
            if (status.pcnt_reset) begin
                skip_cnt  <= 3'd0;
                skip_done <= 1'b0;
                pcnt      <= 8'd0;
                mode3_end <= 1'b0;
            end else begin
                if (advance) begin
                    // Drop scx_fine pixels at pcnt 0
                    if (!skip_done) begin
                        if (!skip_end)
                            skip_cnt <= skip_cnt + 3'd1;
                        else
                            skip_done <= 1'b1;
                    end
                    if (!skip_en && !pcnt_end)
                        pcnt <= pcnt + 8'd1;
                end
                mode3_end <= mode3_end_nxt;
            end
        end
    end

    // One ce behind the internal strobe
    always_ff @(posedge clk) begin
        if (reset)
            lcd_clkena <= 1'b0;
        else if (ce)
            lcd_clkena <= pix_strobe;
    end

    // Transfer is long over by the line end and absent in vblank
    a_no_pixel_blank: assert property (@(posedge clk) disable iff (reset)
        (status.end_of_line || status.vblank) |-> !pix_strobe);

endmodule

`default_nettype wire

// ==== lcd_video.sv ====
// LCD video timing core, bypass form
// Re-enable synchroniser, registers, line timer and pixel pacing
`default_nettype none
`timescale 1ns/1ps

module lcd_video #(
    parameter int H_LAST    = lcd_video_cfg_pkg::H_LAST,
    parameter int V_LAST    = lcd_video_cfg_pkg::V_LAST,
    parameter int V_VISIBLE = lcd_video_cfg_pkg::V_VISIBLE
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ce,
    input  logic                         ce_cpu,
    input  logic                         is_gbc,
    input  logic                         is_gbc_mode,
    input  logic                         palette_off,
    input  lcd_video_bus_pkg::cpu_bus_t  cpu,
    input  lcd_video_cfg_pkg::lcd_mode_t mode_real,
    output logic                         lcd_on,
    output logic                         lcd_clkena,
    output logic                         lcd_vsync,
    output logic                         overwrite,
    output logic                         vsync_overwrite,
    output logic [14:0]                  lcd_data,
    output lcd_video_cfg_pkg::lcd_mode_t mode
);
    import lcd_video_bus_pkg::*;

    logic         lcdc_on;
    logic [2:0]   scx_fine;
    logic [7:0]   pal_lo;
    logic [7:0]   pal_hi;
    logic         restart;
    logic         mode3;
    logic         mode3_end;
    line_status_t status;

    // ------------------------------
    // Control and registers
    // ------------------------------
    lcd_sync_ctrl i_sync (
        .clk             (clk),
        .reset           (reset),
        .ce              (ce),
        .lcdc_on         (lcdc_on),
        .lcd_vsync       (lcd_vsync),
        .mode_real       (mode_real),
        .restart         (restart),
        .overwrite       (overwrite),
        .vsync_overwrite (vsync_overwrite),
        .lcd_on          (lcd_on)
    );

    ppu_regs i_regs (
        .clk         (clk),
        .reset       (reset),
        .ce_cpu      (ce_cpu),
        .is_gbc      (is_gbc),
        .is_gbc_mode (is_gbc_mode),
        .mode3       (mode3),
        .cpu         (cpu),
        .lcdc_on     (lcdc_on),
        .scx_fine    (scx_fine),
        .pal_lo      (pal_lo),
        .pal_hi      (pal_hi)
    );

    // ------------------------------
    // Timing datapaths
    // ------------------------------
    line_timer #(
        .H_LAST    (H_LAST),
        .V_LAST    (V_LAST),
        .V_VISIBLE (V_VISIBLE)
    ) i_timer (
        .clk       (clk),
        .reset     (reset),
        .ce        (ce),
        .restart   (restart),
        .lcd_on    (lcd_on),
        .is_gbc    (is_gbc),
        .mode3_end (mode3_end),
        .status    (status),
        .lcd_vsync (lcd_vsync),
        .mode      (mode),
        .mode3     (mode3)
    );

    pixel_fetch i_fetch (
        .clk        (clk),
        .reset      (reset),
        .ce         (ce),
        .restart    (restart),
        .mode3      (mode3),
        .status     (status),
        .scx_fine   (scx_fine),
        .mode3_end  (mode3_end),
        .lcd_clkena (lcd_clkena)
    );

    // Fixed colour from palette bytes 0 and 1, white otherwise
    assign lcd_data = (is_gbc_mode || !palette_off) ? 15'h7fff : {pal_hi[6:0], pal_lo};

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source
// 100 ns clock, reset held high for the first two rising edges
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam time HALF_PERIOD = 50ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on the second rising edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== lcd_video_tb.sv ====
// LCD video timing core testbench
// Table-driven checks of pixel pacing, frame timing, palette output
// and the LCD re-enable synchroniser
`default_nettype none
`timescale 1ns/1ps

module lcd_video_tb;
    import lcd_video_cfg_pkg::*;
    import lcd_video_bus_pkg::*;

    // A bit over two frames of ce cycles
    localparam int TIMEOUT = 160000;
    localparam int ROWS = 4;
    // Selectors for wait_flag
    localparam int FLAG_OVERWRITE = 0;
    localparam int FLAG_VSYNC_OVR = 1;
    localparam int FLAG_VSYNC = 2;
    localparam int FLAG_RESET = 3;

    // One stimulus row and its expected pixel count
    typedef struct packed {
        logic [2:0] scx;
        logic [7:0] pal_lo;
        logic [7:0] pal_hi;
        logic [7:0] pix_count;
    } stim_row_t;

    logic        clk;
    logic        reset;
    logic        ce;
    logic        ce_cpu;
    logic        is_gbc;
    logic        is_gbc_mode;
    logic        palette_off;
    cpu_bus_t    cpu;
    lcd_mode_t   mode_real;
    logic        lcd_on;
    logic        lcd_clkena;
    logic        lcd_vsync;
    logic        overwrite;
    logic        vsync_overwrite;
    logic [14:0] lcd_data;
    lcd_mode_t   mode;
    stim_row_t   table_rows [ROWS];
    logic [31:0] seed;
    int          errors;
    int          pixels;
    int          xfers;
    logic        vblank_seen;

    tb_clock_gen i_clk_gen (.clk(clk), .reset(reset));

    lcd_video i_dut (
        .clk(clk), .reset(reset), .ce(ce), .ce_cpu(ce_cpu),
        .is_gbc(is_gbc), .is_gbc_mode(is_gbc_mode), .palette_off(palette_off),
        .cpu(cpu), .mode_real(mode_real), .lcd_on(lcd_on), .lcd_clkena(lcd_clkena),
        .lcd_vsync(lcd_vsync), .overwrite(overwrite), .vsync_overwrite(vsync_overwrite),
        .lcd_data(lcd_data), .mode(mode)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic flag_value(input int sel);
        case (sel)
            FLAG_OVERWRITE: return overwrite;
            FLAG_VSYNC_OVR: return vsync_overwrite;
            FLAG_VSYNC:     return lcd_vsync;
            default:        return reset;
        endcase
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Samples on the falling edge away from the DUT's updates
    task automatic wait_flag(input int sel, input logic val, input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout waiting for %s to become %0d", name, val);
                abort_run();
            end
        end while (flag_value(sel) !== val);
    endtask

    // Waits until mode equals m, or differs from it when equal is 0
    task automatic wait_mode(input lcd_mode_t m, input logic equal);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout waiting on STAT mode %0d", m);
                abort_run();
            end
        end while ((mode == m) != equal);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu <= '{sel_reg: 1'b1, wr: 1'b1, addr: addr, di: data};
        @(posedge clk);
        cpu <= '0;
    endtask

    // Pulses after one transfer ends, up to and including the next end
    task automatic count_line_pixels(output int count);
        int   cycles;
        logic seen_xfer;
        wait_mode(MODE_XFER, 1'b1);
        wait_mode(MODE_XFER, 1'b0);
        count = 0;
        seen_xfer = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (lcd_clkena)
                count++;
            if (mode == MODE_XFER)
                seen_xfer = 1'b1;
            if (cycles > TIMEOUT) begin
                $display("Timeout while counting pixels of a line");
                abort_run();
            end
        end while (!(seen_xfer && mode != MODE_XFER));
    endtask

    // Transfer periods and vblank between two vsync rising edges
    task automatic count_frame_xfer(output int count, output logic saw_vblank);
        int   cycles;
        logic prev_xfer;
        logic prev_vsync;
        logic rise;
        wait_flag(FLAG_VSYNC, 1'b0, "lcd_vsync");
        wait_flag(FLAG_VSYNC, 1'b1, "lcd_vsync");
        count = 0;
        saw_vblank = 1'b0;
        cycles = 0;
        prev_xfer = (mode == MODE_XFER);
        prev_vsync = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
            if (mode == MODE_XFER && !prev_xfer)
                count++;
            if (mode == MODE_VBLANK)
                saw_vblank = 1'b1;
            prev_xfer = (mode == MODE_XFER);
            rise = lcd_vsync && !prev_vsync;
            prev_vsync = lcd_vsync;
            if (cycles > TIMEOUT) begin
                $display("Timeout waiting for the next vsync");
                abort_run();
            end
        end while (!rise);
    endtask

    // Fine scroll values, palette bytes from the LCG, 160 pixels per line
    task automatic load_table();
        table_rows[0].scx = 3'd0;
        table_rows[1].scx = 3'd3;
        table_rows[2].scx = 3'd5;
        table_rows[3].scx = 3'd7;
        for (int r = 0; r < ROWS; r++) begin
            seed = lcg_next(seed);
            table_rows[r].pal_lo = seed[23:16];
            seed = lcg_next(seed);
            table_rows[r].pal_hi = seed[23:16];
            table_rows[r].pix_count = 8'd160;
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        ce = 1'b1;
        ce_cpu = 1'b1;
        is_gbc = 1'b0;
        is_gbc_mode = 1'b0;
        palette_off = 1'b0;
        cpu = '0;
        mode_real = MODE_HBLANK;
        errors = 0;
        seed = 32'd36575;
        load_table();
        wait_flag(FLAG_RESET, 1'b0, "reset release");

        // Idle outputs out of reset
        check_value("overwrite", overwrite, 0);
        check_value("vsync_overwrite", vsync_overwrite, 0);
        check_value("lcd_vsync", lcd_vsync, 0);
        check_value("lcd_clkena", lcd_clkena, 0);
        check_value("lcd_on", lcd_on, 1);

        for (int r = 0; r < ROWS; r++) begin
            // Registers change only in vblank away from mode 3
            wait_mode(MODE_VBLANK, 1'b1);
            write_reg(8'h43, {5'd0, table_rows[r].scx});
            write_reg(8'h68, 8'h80);
            write_reg(8'h69, table_rows[r].pal_lo);
            write_reg(8'h69, table_rows[r].pal_hi);
            @(posedge clk);
            palette_off <= 1'b1;
            @(negedge clk);
            check_value("lcd_data", lcd_data,
                        {table_rows[r].pal_hi[6:0], table_rows[r].pal_lo});
            @(posedge clk);
            palette_off <= 1'b0;
            @(negedge clk);
            check_value("lcd_data", lcd_data, 15'h7fff);
            // Second visible line of the next frame
            count_line_pixels(pixels);
            check_value("lcd_clkena count", pixels, table_rows[r].pix_count);
        end

        count_frame_xfer(xfers, vblank_seen);
        check_value("xfer periods", xfers, 144);
        check_value("vblank seen", vblank_seen, 1);

        // LCD off then on, then walk the real panel through its modes
        write_reg(8'h40, 8'h00);
        write_reg(8'h40, 8'h80);
        wait_flag(FLAG_OVERWRITE, 1'b1, "overwrite");
        wait_flag(FLAG_VSYNC_OVR, 1'b1, "vsync_overwrite");
        @(posedge clk);
        mode_real <= MODE_VBLANK;
        repeat (4) @(posedge clk);
        mode_real <= MODE_OAM;
        repeat (4) @(posedge clk);
        mode_real <= MODE_HBLANK;
        wait_flag(FLAG_OVERWRITE, 1'b0, "overwrite");
        wait_flag(FLAG_VSYNC_OVR, 1'b0, "vsync_overwrite");
        check_value("overwrite", overwrite, 0);
        // Synchroniser back out of its sync states, panel enable unmasked
        check_value("lcd_on", lcd_on, 1);

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== lcd_video.f ====
lcd_video_cfg_pkg.sv
lcd_video_bus_pkg.sv
lcd_sync_ctrl.sv
ppu_regs.sv
line_timer.sv
pixel_fetch.sv
lcd_video.sv
tb_clock_gen.sv
lcd_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LCD video testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module lcd_video_tb \
    -f lcd_video.f -o lcd_video_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lcd_video_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, exit status $sim_status"
    exit 1
fi
